// ==== timer_pkg.sv ====
package timer_pkg;

    localparam int DATA_W = 32;  // Register bus width

    // Counting behavior selected through CTRL[1:0]
    typedef enum logic [1:0] {
        mode_off      = 2'd0,
        mode_one_shot = 2'd1,
        mode_periodic = 2'd2,
        mode_pwm      = 2'd3
    } timer_mode_t;

    typedef enum logic [2:0] {
        addr_ctrl     = 3'd0,
        addr_prescale = 3'd1,
        addr_reload   = 3'd2,
        addr_compare  = 3'd3,
        addr_count    = 3'd4,  // Read only
        addr_status   = 3'd5
    } reg_addr_t;

    localparam int CTRL_MODE_LSB  = 0;
    localparam int CTRL_MODE_MSB  = 1;
    localparam int CTRL_START_BIT = 2;  // Write only, reads as zero
    localparam int CTRL_STOP_BIT  = 3;  // Write only, reads as zero

    localparam int STATUS_TIMEOUT_BIT = 0;  // Sticky, write one to clear

endpackage

// ==== timer_cfg_if.sv ====
`timescale 1ns/10ps

interface timer_cfg_if #(
    parameter int COUNT_W = 32,
    parameter int PRESC_W = 16
);
    import timer_pkg::*;

    timer_mode_t        mode;
    logic [PRESC_W-1:0] prescaler;    // Tick every prescaler+1 cycles
    logic [COUNT_W-1:0] reload_val;
    logic [COUNT_W-1:0] compare_val;  // PWM high time in ticks
    logic               start;        // One-cycle pulses from CTRL writes
    logic               stop;
    logic               running;
    logic               tick;
    logic               timeout;      // End of count in one-shot or periodic
    logic [COUNT_W-1:0] count;

    modport regs (
        output mode, prescaler, reload_val, compare_val, start, stop,
        input  timeout, count
    );

    modport presc (
        input  running, prescaler,
        output tick
    );

    modport dpath (
        input  mode, reload_val, compare_val, start, stop, tick,
        output running, timeout, count
    );

endinterface

// ==== timer_regs.sv ====
`timescale 1ns/10ps

module timer_regs #(
    parameter int COUNT_W = 32,
    parameter int PRESC_W = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_en,
    input  logic                         rd_en,
    input  timer_pkg::reg_addr_t         addr,
    input  logic [timer_pkg::DATA_W-1:0] wdata,
    output logic [timer_pkg::DATA_W-1:0] rdata,
    output logic                         irq,
    timer_cfg_if.regs                    cfg
);
    import timer_pkg::*;

    timer_mode_t        mode_q;
    logic [PRESC_W-1:0] presc_q;
    logic [COUNT_W-1:0] reload_q;
    logic [COUNT_W-1:0] compare_q;
    logic               start_q;
    logic               stop_q;
    logic               timeout_flag;
    logic               status_clear;

    // Config registers and CTRL pulse generation
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q    <= mode_off;
            presc_q   <= '0;
            reload_q  <= '0;
            compare_q <= '0;
            start_q   <= 1'b0;
            stop_q    <= 1'b0;
        end else begin
            start_q <= 1'b0;  // Pulses last one cycle
            stop_q  <= 1'b0;
            if (wr_en) begin
                case (addr)
                    addr_ctrl: begin
                        mode_q  <= timer_mode_t'(wdata[CTRL_MODE_MSB:CTRL_MODE_LSB]);
                        start_q <= wdata[CTRL_START_BIT];
                        stop_q  <= wdata[CTRL_STOP_BIT];
                    end
                    addr_prescale: presc_q   <= wdata[PRESC_W-1:0];
                    addr_reload:   reload_q  <= wdata[COUNT_W-1:0];
                    addr_compare:  compare_q <= wdata[COUNT_W-1:0];
                    default: ;  // COUNT is read only, STATUS handled below
                endcase
            end
        end
    end

    assign status_clear = wr_en && (addr == addr_status) && wdata[STATUS_TIMEOUT_BIT];

    // A new timeout beats a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timeout_flag <= 1'b0;
        end else if (cfg.timeout) begin
            timeout_flag <= 1'b1;
        end else if (status_clear) begin
            timeout_flag <= 1'b0;
        end
    end

    assign irq = timeout_flag;

    always_comb begin
        rdata = '0;
        case (addr)
            addr_ctrl:     rdata = DATA_W'(mode_q);  // Start and stop read as zero
            addr_prescale: rdata = DATA_W'(presc_q);
            addr_reload:   rdata = DATA_W'(reload_q);
            addr_compare:  rdata = DATA_W'(compare_q);
            addr_count:    rdata = DATA_W'(cfg.count);  // Live counter value
            addr_status:   rdata[STATUS_TIMEOUT_BIT] = timeout_flag & rd_en;
            default:       rdata = '0;
        endcase
    end

    assign cfg.mode        = mode_q;
    assign cfg.prescaler   = presc_q;
    assign cfg.reload_val  = reload_q;
    assign cfg.compare_val = compare_q;
    assign cfg.start       = start_q;
    assign cfg.stop        = stop_q;

endmodule

// ==== timer_prescaler.sv ====
`timescale 1ns/10ps

module timer_prescaler #(
    parameter int PRESC_W = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    timer_cfg_if.presc cfg
);

    logic [PRESC_W-1:0] presc_cnt;
    logic               tick_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc_cnt <= '0;
            tick_q    <= 1'b0;
        end else if (!cfg.running) begin
            presc_cnt <= '0;  // Restart phase on every run
            tick_q    <= 1'b0;
        end else if (presc_cnt == cfg.prescaler) begin
            presc_cnt <= '0;
            tick_q    <= 1'b1;  // One tick per prescaler+1 cycles
        end else begin
            presc_cnt <= presc_cnt + 1'b1;
            tick_q    <= 1'b0;
        end
    end

    assign cfg.tick = tick_q;

endmodule

// ==== timer_datapath.sv ====
`timescale 1ns/10ps

module timer_datapath #(
    parameter int COUNT_W = 32,
    parameter int PRESC_W = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    timer_cfg_if.dpath cfg,
    output logic       pwm_out
);
    import timer_pkg::*;

    logic [COUNT_W-1:0] count_q;
    logic               running_q;
    logic               tick_en;       // Tick that the counter acts on
    logic               end_of_count;  // Last tick of a period
    logic [COUNT_W-1:0] pwm_thresh;

    // Off mode ignores ticks, other modes take the current mode at each tick
    assign tick_en      = running_q && cfg.tick && (cfg.mode != mode_off);
    assign end_of_count = tick_en && (count_q == COUNT_W'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q   <= '0;
            running_q <= 1'b0;
        end else if (cfg.stop) begin
            running_q <= 1'b0;  // Count holds its value
        end else if (cfg.start && !running_q) begin
            count_q   <= cfg.reload_val;
            running_q <= 1'b1;
        end else if (end_of_count) begin
            case (cfg.mode)
                mode_one_shot: begin
                    count_q   <= '0;
                    running_q <= 1'b0;
                end
                mode_periodic,
                mode_pwm: count_q <= cfg.reload_val;
                default: ;
            endcase
        end else if (tick_en) begin
            count_q <= count_q - 1'b1;
        end
    end

    // Timeout is high for the cycle of the last tick, so the status flag
    // catches it on the same edge that ends the period
    assign cfg.timeout = end_of_count &&
                         ((cfg.mode == mode_one_shot) || (cfg.mode == mode_periodic));

    assign cfg.running = running_q;
    assign cfg.count   = count_q;

    // High during the first compare_val ticks of each period
    assign pwm_thresh = cfg.reload_val - cfg.compare_val;

    always_comb begin
        pwm_out = 1'b0;
        if (running_q && (cfg.mode == mode_pwm)) begin
            pwm_out = (count_q > pwm_thresh);
        end
    end

endmodule

// ==== timer_top.sv ====
`timescale 1ns/10ps

module timer_top #(
    parameter int COUNT_W = 32,  // At most DATA_W
    parameter int PRESC_W = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_en,
    input  logic                         rd_en,
    input  timer_pkg::reg_addr_t         addr,
    input  logic [timer_pkg::DATA_W-1:0] wdata,
    output logic [timer_pkg::DATA_W-1:0] rdata,
    output logic                         irq,
    output logic                         pwm_out
);

    // Config, pulses and status between the three blocks
    timer_cfg_if #(
        .COUNT_W(COUNT_W),
        .PRESC_W(PRESC_W)
    ) cfg_if ();

    timer_regs #(
        .COUNT_W(COUNT_W),
        .PRESC_W(PRESC_W)
    ) regs_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (wr_en),
        .rd_en (rd_en),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .irq   (irq),
        .cfg   (cfg_if)
    );

    timer_prescaler #(
        .PRESC_W(PRESC_W)
    ) prescaler_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (cfg_if)
    );

    timer_datapath #(
        .COUNT_W(COUNT_W),
        .PRESC_W(PRESC_W)
    ) datapath_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (cfg_if),
        .pwm_out (pwm_out)
    );

endmodule

// ==== tb_timer.sv ====
`timescale 1ns/10ps

module tb_timer;
    import timer_pkg::*;

    localparam int MAX_R      = 9;
    localparam int MAX_P      = 3;
    localparam int MAX_PERIOD = MAX_R * (MAX_P + 1);
    // Read-back, one-shot, periodic, PWM, stop and restart
    localparam int SCENARIO_CYCLES = 20 + (MAX_PERIOD + 20) + (4 * MAX_PERIOD + 30)
                                   + (3 * MAX_PERIOD + 20) + (2 * MAX_PERIOD + 50);
    localparam int CYCLE_LIMIT = SCENARIO_CYCLES + 2000;

    logic              clk;
    logic              rst_n;
    logic              wr_en;
    logic              rd_en;
    reg_addr_t         addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              irq;
    logic              pwm_out;

    integer seed = 21413;
    int     cycle_cnt = 0;  // Rising edges since time zero
    int     last_wr_cycle;  // Edge that captured the latest write
    int     r_val;
    int     p_val;
    int     c_val;

    timer_top timer_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),
        .irq     (irq),
        .pwm_out (pwm_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, the timer never finished", CYCLE_LIMIT);
            report_fail();
        end
    end

    task automatic report_fail();
        $display(">>> FAIL");
        $fatal(1, "stopping at the first failure");
    endtask

    function automatic int ref_period(int r, int p);
        return r * (p + 1);
    endfunction

    function automatic int ref_pwm_high_cycles(int c, int p);
        return c * (p + 1);
    endfunction

    // Count left after a stop written d cycles past the start write
    function automatic int ref_stopped_count(int r, int p, int d);
        return r - (d - 1) / (p + 1);
    endfunction

    function automatic logic [DATA_W-1:0] ctrl_word(timer_mode_t m, logic start, logic stop);
        logic [DATA_W-1:0] w;
        w = '0;
        w[CTRL_MODE_MSB:CTRL_MODE_LSB] = m;
        w[CTRL_START_BIT] = start;
        w[CTRL_STOP_BIT]  = stop;
        return w;
    endfunction

    task automatic check_data(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("error %s: expected %0h, actual %0h", name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("error %s: expected %b, actual %b", name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            $display("error %s: expected %0d, actual %0d", name, exp, act);
            report_fail();
        end
    endtask

    // Write is captured on the rising edge after the call
    task automatic write_reg(reg_addr_t a, logic [DATA_W-1:0] d);
        addr  = a;
        wdata = d;
        wr_en = 1'b1;
        @(negedge clk);
        wr_en = 1'b0;
        last_wr_cycle = cycle_cnt;
    endtask

    task automatic read_reg(reg_addr_t a, output logic [DATA_W-1:0] d);
        addr  = a;
        rd_en = 1'b1;
        #5;
        d = rdata;  // Settles well before the next edge
        @(negedge clk);
        rd_en = 1'b0;
    endtask

    task automatic idle(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_irq_rise(logic no_zero_count, output int when);
        addr = addr_count;  // Watch the live count while waiting
        @(negedge clk);
        while (!irq) begin
            if (no_zero_count && rdata == '0) begin
                $display("COUNT read zero while the periodic timer was running");
                report_fail();
            end
            @(negedge clk);
        end
        when = cycle_cnt;
    endtask

    task automatic clear_irq(string name);
        write_reg(addr_status, DATA_W'(1));
        check_bit(name, 1'b0, irq);
    endtask

    // Also clears a timeout that lands on the stop edge
    task automatic stop_timer(timer_mode_t m);
        write_reg(addr_ctrl, ctrl_word(m, 1'b0, 1'b1));
        idle(2);
        clear_irq("irq after stop");
    endtask

    task automatic pick_random();
        r_val = 2 + ($unsigned($random(seed)) % 8);
        p_val = $unsigned($random(seed)) % 4;
        c_val = 1 + ($unsigned($random(seed)) % (r_val - 1));
        write_reg(addr_prescale, DATA_W'(p_val));
        write_reg(addr_reload, DATA_W'(r_val));
        write_reg(addr_compare, DATA_W'(c_val));
    endtask

    initial begin
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] exp;
        int t_start;
        int t_irq;
        int t_prev;
        int high_cnt;
        int d;

        rst_n = 1'b0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        addr  = addr_ctrl;
        wdata = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("reset irq", 1'b0, irq);
        check_bit("reset pwm_out", 1'b0, pwm_out);

        exp = $unsigned($random(seed)) & 32'h0000_ffff;  // Prescaler is 16 bits by default
        write_reg(addr_prescale, exp);
        read_reg(addr_prescale, rd);
        check_data("readback prescale", exp, rd);
        exp = $random(seed);
        write_reg(addr_reload, exp);
        read_reg(addr_reload, rd);
        check_data("readback reload", exp, rd);
        exp = $random(seed);
        write_reg(addr_compare, exp);
        read_reg(addr_compare, rd);
        check_data("readback compare", exp, rd);
        write_reg(addr_ctrl, ctrl_word(mode_pwm, 1'b1, 1'b0));  // PWM never times out
        read_reg(addr_ctrl, rd);
        check_data("readback ctrl start", DATA_W'(mode_pwm), rd);
        write_reg(addr_ctrl, ctrl_word(mode_off, 1'b0, 1'b1));
        read_reg(addr_ctrl, rd);
        check_data("readback ctrl stop", DATA_W'(mode_off), rd);

        pick_random();
        write_reg(addr_ctrl, ctrl_word(mode_one_shot, 1'b1, 1'b0));
        t_start = last_wr_cycle;
        wait_irq_rise(1'b0, t_irq);
        check_count("one-shot irq delay", ref_period(r_val, p_val) + 2, t_irq - t_start);
        read_reg(addr_count, rd);
        check_data("one-shot count", '0, rd);
        read_reg(addr_status, rd);
        check_data("one-shot status", DATA_W'(1), rd);
        idle(5);
        check_bit("one-shot irq held", 1'b1, irq);
        clear_irq("one-shot clear");
        idle(10);
        check_bit("one-shot irq after clear", 1'b0, irq);

        pick_random();
        write_reg(addr_ctrl, ctrl_word(mode_periodic, 1'b1, 1'b0));
        t_start = last_wr_cycle;
        wait_irq_rise(1'b1, t_prev);
        check_count("periodic first irq", ref_period(r_val, p_val) + 2, t_prev - t_start);
        repeat (3) begin
            clear_irq("periodic clear");
            wait_irq_rise(1'b1, t_irq);
            check_count("periodic interval", ref_period(r_val, p_val), t_irq - t_prev);
            t_prev = t_irq;
        end
        stop_timer(mode_periodic);

        pick_random();
        write_reg(addr_ctrl, ctrl_word(mode_pwm, 1'b1, 1'b0));
        idle(ref_period(r_val, p_val) + 4);  // Skip the longer first period
        high_cnt = 0;
        repeat (ref_period(r_val, p_val)) begin
            @(negedge clk);
            if (pwm_out) begin
                high_cnt++;
            end
            check_bit("pwm irq", 1'b0, irq);
        end
        check_count("pwm high cycles", ref_pwm_high_cycles(c_val, p_val), high_cnt);
        stop_timer(mode_pwm);

        pick_random();
        write_reg(addr_ctrl, ctrl_word(mode_one_shot, 1'b1, 1'b0));
        d = ref_period(r_val, p_val) / 2;  // Stop halfway through the count
        idle(d);
        write_reg(addr_ctrl, ctrl_word(mode_one_shot, 1'b0, 1'b1));
        idle(1);
        exp = DATA_W'(ref_stopped_count(r_val, p_val, d));
        read_reg(addr_count, rd);
        check_data("stopped count", exp, rd);
        idle(19);
        read_reg(addr_count, rd);
        check_data("stopped count 20 cycles later", exp, rd);
        check_bit("stopped irq", 1'b0, irq);
        write_reg(addr_ctrl, ctrl_word(mode_one_shot, 1'b1, 1'b0));
        t_start = last_wr_cycle;
        wait_irq_rise(1'b0, t_irq);
        check_count("restart irq delay", ref_period(r_val, p_val) + 2, t_irq - t_start);
        clear_irq("restart clear");

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
timer_pkg.sv
timer_cfg_if.sv
timer_regs.sv
timer_prescaler.sv
timer_datapath.sv
timer_top.sv
tb_timer.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
LINT     = --lint-only --timing -Wall
TOP      = tb_timer
FILELIST = compile.f
OBJ_DIR  = obj_dir
PASS_MSG = >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
